//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= dcache_tb
FILELIST  ?= compile.f
PASS_MSG  := TESTBENCH PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build output"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

//--- compile.f
verilog/dcache_pkg.sv
verilog/dcache_sram.sv
verilog/dcache_line_access.sv
verilog/dcache_ctrl.sv
verilog/main_memory.sv
verilog/dcache_subsystem_top.sv
verification/dcache_tb.sv

//--- verification/dcache_input.txt
# op addr wdata expected name (hex, expected is ignored for writes)
# unwritten memory word w reads as w ^ a5a50000
R 00000000 00000000 a5a50000 first_read_miss
R 00000040 00000000 a5a50010 read_miss
R 00000044 00000000 a5a50011 read_hit_same_line
W 00000048 12345678 00000000 write_hit
R 00000048 00000000 12345678 read_written_word
R 0000004c 00000000 a5a50013 read_neighbor_word
R 00000448 00000000 a5a50112 dirty_evict_read
R 00000048 00000000 12345678 read_after_writeback
R 00000040 00000000 a5a50010 read_writeback_neighbor
W 00000100 cafef00d 00000000 write_miss
R 00000100 00000000 cafef00d read_allocated_word
R 0000011c 00000000 a5a50047 read_allocated_rest
W 00000204 deadbeef 00000000 mix_write_a
R 00000604 00000000 a5a50181 mix_evict_a
W 000006f0 0badc0de 00000000 mix_write_b
R 00000204 00000000 deadbeef mix_reload_a
R 00000200 00000000 a5a50080 mix_neighbor_a
R 000006f0 00000000 0badc0de mix_hit_b
R 000002f0 00000000 a5a500bc mix_evict_b
R 000006f0 00000000 0badc0de mix_reload_b
R 000007fc 00000000 a5a501ff mix_top_word
R 000003fc 00000000 a5a500ff mix_top_alias

//--- verification/dcache_tb.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_tb
  import dcache_pkg::*;
();

  logic               clk_i;
  logic               rst_i;
  core_req_t          core_req;
  logic [REG_LEN-1:0] rdata;
  logic               stall;

  int                 pass_count;
  int                 fail_count;
  bit                 timed_out;
  int                 fd;
  int                 fields;
  int                 gap;
  bit                 first;
  logic [8*96-1:0]    line;
  logic [7:0]         op;
  logic [REG_LEN-1:0] addr;
  logic [REG_LEN-1:0] wdata;
  logic [REG_LEN-1:0] expected;
  logic [8*24-1:0]    name;

  // lines the cache should hold by now
  bit                  model_valid [CACHE_LINES];
  logic [TAG_BITS-1:0] model_tag   [CACHE_LINES];

  dcache_subsystem_top dcache_subsystem_top_i (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .core_req_i (core_req),
    .rdata_o    (rdata),
    .stall_o    (stall)
  );

  always #10 clk_i = ~clk_i;

  // outputs are sampled at the falling edge, half a cycle after the drive
  task automatic run_transaction(
    input logic [7:0]         t_op,
    input logic [REG_LEN-1:0] t_addr,
    input logic [REG_LEN-1:0] t_wdata,
    input logic [REG_LEN-1:0] t_expected,
    input logic [8*24-1:0]    t_name
  );
    core_req_t           req;
    int                  waited;
    bit                  ok;
    int                  slot;
    logic [TAG_BITS-1:0] line_tag;
    bit                  expect_hit;
    req.read  = (t_op == "R");
    req.write = (t_op == "W");
    req.addr  = t_addr;
    req.wdata = t_wdata;
    ok = 1'b1;
    waited = 0;
    // direct mapped, one line per slot
    slot       = int'((t_addr >> OFFSET_BITS) % CACHE_LINES);
    line_tag   = TAG_BITS'(t_addr >> (OFFSET_BITS + INDEX_BITS));
    expect_hit = model_valid[slot] && (model_tag[slot] == line_tag);
    @(posedge clk_i);
    core_req <= req;
    @(negedge clk_i);
    // a hit completes in the cycle of the request
    assert (stall == !expect_hit) else begin
      $display("FAILED %0s stall_o expected %0b actual %0b", t_name, !expect_hit, stall);
      ok = 1'b0;
    end
    while (stall && waited < 100) begin
      @(negedge clk_i);
      waited++;
    end
    if (stall) begin
      $display("%0s timed out waiting for stall_o to fall", t_name);
      ok = 1'b0;
      timed_out = 1'b1;
    end else begin
      model_valid[slot] = 1'b1;
      model_tag[slot]   = line_tag;
      if (req.read) begin
        assert (rdata == t_expected) else begin
          $display("FAILED %0s expected %h actual %h", t_name, t_expected, rdata);
          ok = 1'b0;
        end
      end
    end
    if (ok) begin
      pass_count++;
      $display("ok   %0s after %0d wait cycles", t_name, waited);
    end else begin
      fail_count++;
      $display("bad  %0s after %0d wait cycles", t_name, waited);
    end
  endtask

  initial begin
    clk_i = 1'b0;
    rst_i = 1'b0;
    core_req = '0;
    pass_count = 0;
    fail_count = 0;
    timed_out = 1'b0;
    first = 1'b1;
    for (int i = 0; i < CACHE_LINES; i++) begin
      model_valid[i] = 1'b0;
      model_tag[i]   = '0;
    end
    void'($urandom(26));
    repeat (4) @(posedge clk_i);
    rst_i <= 1'b1;
    @(negedge clk_i);
    assert (!stall) else begin
      $display("stall_o is high after reset with no request");
      fail_count++;
    end
    $display("done reset_idle");
    fd = $fopen("verification/dcache_input.txt", "r");
    if (fd == 0) begin
      $display("cannot open the transaction file");
      fail_count++;
    end else begin
      while (!$feof(fd) && !timed_out) begin
        if ($fgets(line, fd) != 0) begin
          fields = $sscanf(line, "%s %h %h %h %s", op, addr, wdata, expected, name);
          // comment and blank lines do not parse into five fields
          if (fields == 5 && (op == "R" || op == "W")) begin
            run_transaction(op, addr, wdata, expected, name);
            first = 1'b0;
            gap = int'($urandom % 4);
            if (gap > 0) begin
              @(posedge clk_i);
              core_req <= '0;
              repeat (gap - 1) @(posedge clk_i);
            end
          end
        end
      end
      $fclose(fd);
      @(posedge clk_i);
      core_req <= '0;
    end
    if (first) begin
      $display("no transaction was read from the file");
      fail_count++;
    end
    $display("passed %0d, failed %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/dcache_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_ctrl
  import dcache_pkg::*;
(
  input  wire logic                 clk_i,
  input  wire logic                 rst_i,
  input  wire core_req_t            req_i,
  input  wire logic                 hit_i,
  input  wire logic                 dirty_i,
  input  wire logic [REG_LEN-1:0]   victim_addr_i,
  input  wire logic [REG_LEN-1:0]   fetch_addr_i,
  input  wire logic [LINE_BITS-1:0] victim_line_i,
  input  wire mem_rsp_t             mem_rsp_i,
  output mem_req_t                  mem_req_o,
  output logic                      fill_o
);

  cache_state_e state_q;
  logic         enable_q;
  logic         write_q;
  logic         fill_q;
  logic         miss;

  assign miss = (req_i.read | req_i.write) & ~hit_i;

  always_ff @(posedge clk_i or negedge rst_i) begin
    if (!rst_i) begin
      state_q  <= ST_IDLE;
      enable_q <= 1'b0;
      write_q  <= 1'b0;
      fill_q   <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (miss) begin
            enable_q <= 1'b1;
            if (dirty_i) begin
              // victim goes out first
              write_q <= 1'b1;
              state_q <= ST_WRITEBACK;
            end else begin
              write_q <= 1'b0;
              state_q <= ST_READMISS;
            end
          end
        end
        ST_WRITEBACK: begin
          // enable stays high, memory restarts its count for the fetch
          if (mem_rsp_i.ack) begin
            write_q <= 1'b0;
            state_q <= ST_READMISS;
          end
        end
        ST_READMISS: begin
          if (mem_rsp_i.ack) begin
            enable_q <= 1'b0;
            fill_q   <= 1'b1;
            state_q  <= ST_FILL;
          end
        end
        ST_FILL: begin
          // line is written at the end of this cycle
          fill_q  <= 1'b0;
          state_q <= ST_IDLE;
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  always_comb begin
    mem_req_o.enable = enable_q;
    mem_req_o.write  = write_q;
    mem_req_o.addr   = (state_q == ST_WRITEBACK) ? victim_addr_i : fetch_addr_i;
    mem_req_o.data   = victim_line_i;
  end

  assign fill_o = fill_q;

endmodule

`default_nettype wire

//--- verilog/dcache_line_access.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_line_access
  import dcache_pkg::*;
(
  input  wire core_req_t             req_i,
  input  wire tag_entry_t            entry_i,
  input  wire logic [LINE_BITS-1:0]  line_i,
  input  wire logic [LINE_BITS-1:0]  fill_line_i,
  output logic [INDEX_BITS-1:0]      index_o,
  output logic                       hit_o,
  output logic                       write_hit_o,
  output logic                       stall_o,
  output logic [REG_LEN-1:0]         rdata_o,
  output logic [LINE_BITS-1:0]       sram_data_o,
  output tag_entry_t                 tag_o,
  output logic [REG_LEN-1:0]         victim_addr_o,
  output logic [REG_LEN-1:0]         fetch_addr_o
);

  logic [TAG_BITS-1:0]      req_tag;
  logic [WORD_SEL_BITS-1:0] word_sel;
  logic [LINE_BITS-1:0]     merged_line;
  logic                     req_present;

  // low two address bits are dropped, word accesses only
  assign req_tag  = req_i.addr[REG_LEN-1 -: TAG_BITS];
  assign index_o  = req_i.addr[OFFSET_BITS +: INDEX_BITS];
  assign word_sel = req_i.addr[OFFSET_BITS-1 -: WORD_SEL_BITS];

  assign req_present = req_i.read | req_i.write;
  assign hit_o       = entry_i.valid && (entry_i.tag == req_tag);
  assign write_hit_o = hit_o & req_i.write;
  assign stall_o     = req_present & ~hit_o;

  assign rdata_o = line_i[word_sel*REG_LEN +: REG_LEN];

  always_comb begin
    merged_line = line_i;
    merged_line[word_sel*REG_LEN +: REG_LEN] = req_i.wdata;
  end

  // a fill stores the memory line clean, a write hit marks it dirty
  assign sram_data_o = write_hit_o ? merged_line : fill_line_i;
  assign tag_o.valid = 1'b1;
  assign tag_o.dirty = write_hit_o;
  assign tag_o.tag   = req_tag;

  assign victim_addr_o = {entry_i.tag, index_o, {OFFSET_BITS{1'b0}}};
  assign fetch_addr_o  = {req_tag, index_o, {OFFSET_BITS{1'b0}}};

endmodule

`default_nettype wire

//--- verilog/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

  localparam int REG_LEN     = 32;
  localparam int LINE_BITS   = 256;
  localparam int OFFSET_BITS = 5;
  localparam int INDEX_BITS  = 5;
  localparam int TAG_BITS    = REG_LEN - INDEX_BITS - OFFSET_BITS;
  localparam int MEM_LINES   = 64;
  localparam int MEM_LATENCY = 4;

  // derived sizes
  localparam int CACHE_LINES    = 1 << INDEX_BITS;
  localparam int WORDS_PER_LINE = LINE_BITS / REG_LEN;
  localparam int WORD_SEL_BITS  = $clog2(WORDS_PER_LINE);
  localparam int MEM_INDEX_BITS = $clog2(MEM_LINES);
  localparam int MEM_CNT_BITS   = $clog2(MEM_LATENCY + 1);

  typedef struct packed {
    logic               read;
    logic               write;
    logic [REG_LEN-1:0] addr;
    logic [REG_LEN-1:0] wdata;
  } core_req_t;

  // 24 bits per entry
  typedef struct packed {
    logic                valid;
    logic                dirty;
    logic [TAG_BITS-1:0] tag;
  } tag_entry_t;

  typedef struct packed {
    logic                 enable;
    logic                 write;
    logic [REG_LEN-1:0]   addr;
    logic [LINE_BITS-1:0] data;
  } mem_req_t;

  typedef struct packed {
    logic                 ack;
    logic [LINE_BITS-1:0] data;
  } mem_rsp_t;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WRITEBACK,
    ST_READMISS,
    ST_FILL
  } cache_state_e;

endpackage

`default_nettype wire

//--- verilog/dcache_sram.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_sram
  import dcache_pkg::*;
(
  input  wire logic                  clk_i,
  input  wire logic                  rst_i,
  input  wire logic [INDEX_BITS-1:0] index_i,
  input  wire logic                  write_i,
  input  wire tag_entry_t            tag_i,
  input  wire logic [LINE_BITS-1:0]  data_i,
  output tag_entry_t                 tag_o,
  output logic [LINE_BITS-1:0]       data_o
);

  tag_entry_t           tag_mem  [CACHE_LINES];
  logic [LINE_BITS-1:0] data_mem [CACHE_LINES];

  // reset clears the tag entries only
  always_ff @(posedge clk_i or negedge rst_i) begin
    if (!rst_i) begin
      for (int i = 0; i < CACHE_LINES; i++) begin
        tag_mem[i] <= '0;
      end
    end else if (write_i) begin
      tag_mem[index_i] <= tag_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (write_i) begin
      data_mem[index_i] <= data_i;
    end
  end

  // asynchronous read at the request index
  assign tag_o  = tag_mem[index_i];
  assign data_o = data_mem[index_i];

endmodule

`default_nettype wire

//--- verilog/dcache_subsystem_top.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_subsystem_top
  import dcache_pkg::*;
(
  input  wire logic          clk_i,
  input  wire logic          rst_i,
  input  wire core_req_t     core_req_i,
  output logic [REG_LEN-1:0] rdata_o,
  output logic               stall_o
);

  logic [INDEX_BITS-1:0] index;
  logic                  hit;
  logic                  write_hit;
  logic                  fill;
  logic                  sram_we;
  tag_entry_t            sram_entry;
  tag_entry_t            new_entry;
  logic [LINE_BITS-1:0]  sram_line;
  logic [LINE_BITS-1:0]  sram_wdata;
  logic [REG_LEN-1:0]    victim_addr;
  logic [REG_LEN-1:0]    fetch_addr;
  mem_req_t              mem_req;
  mem_rsp_t              mem_rsp;

  // fill from memory or commit of a write hit
  assign sram_we = fill | write_hit;

  dcache_line_access dcache_line_access_i (
    .req_i         (core_req_i),
    .entry_i       (sram_entry),
    .line_i        (sram_line),
    .fill_line_i   (mem_rsp.data),
    .index_o       (index),
    .hit_o         (hit),
    .write_hit_o   (write_hit),
    .stall_o       (stall_o),
    .rdata_o       (rdata_o),
    .sram_data_o   (sram_wdata),
    .tag_o         (new_entry),
    .victim_addr_o (victim_addr),
    .fetch_addr_o  (fetch_addr)
  );

  dcache_ctrl dcache_ctrl_i (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .req_i         (core_req_i),
    .hit_i         (hit),
    .dirty_i       (sram_entry.dirty),
    .victim_addr_i (victim_addr),
    .fetch_addr_i  (fetch_addr),
    .victim_line_i (sram_line),
    .mem_rsp_i     (mem_rsp),
    .mem_req_o     (mem_req),
    .fill_o        (fill)
  );

  dcache_sram dcache_sram_i (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .index_i (index),
    .write_i (sram_we),
    .tag_i   (new_entry),
    .data_i  (sram_wdata),
    .tag_o   (sram_entry),
    .data_o  (sram_line)
  );

  main_memory main_memory_i (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .req_i (mem_req),
    .rsp_o (mem_rsp)
  );

endmodule

`default_nettype wire

//--- verilog/main_memory.sv
`timescale 1ns/1ns
`default_nettype none

module main_memory
  import dcache_pkg::*;
(
  input  wire logic     clk_i,
  input  wire logic     rst_i,
  input  wire mem_req_t req_i,
  output mem_rsp_t      rsp_o
);

  logic [LINE_BITS-1:0]      mem [MEM_LINES];
  logic [LINE_BITS-1:0]      rdata_q;
  logic [MEM_CNT_BITS-1:0]   count_q;
  logic                      ack_q;
  logic                      do_access;
  logic [MEM_INDEX_BITS-1:0] line_sel;

  // upper address bits fall outside the 2 KB space
  assign line_sel  = req_i.addr[OFFSET_BITS +: MEM_INDEX_BITS];
  assign do_access = req_i.enable && !ack_q &&
                     (count_q == MEM_CNT_BITS'(MEM_LATENCY - 1));

  always_ff @(posedge clk_i or negedge rst_i) begin
    if (!rst_i) begin
      count_q <= '0;
      ack_q   <= 1'b0;
    end else if (ack_q) begin
      // count again from the next cycle
      ack_q   <= 1'b0;
      count_q <= '0;
    end else if (do_access) begin
      ack_q   <= 1'b1;
      count_q <= '0;
    end else if (req_i.enable) begin
      count_q <= count_q + MEM_CNT_BITS'(1);
    end else begin
      count_q <= '0;
    end
  end

  // word w holds w ^ 32'hA5A50000 after reset
  always_ff @(posedge clk_i or negedge rst_i) begin
    if (!rst_i) begin
      for (int l = 0; l < MEM_LINES; l++) begin
        for (int k = 0; k < WORDS_PER_LINE; k++) begin
          mem[l][k*REG_LEN +: REG_LEN] <= REG_LEN'(l*WORDS_PER_LINE + k) ^ 32'hA5A50000;
        end
      end
    end else if (do_access && req_i.write) begin
      mem[line_sel] <= req_i.data;
    end
  end

  // held until the next read so a fill can use it after ack
  always_ff @(posedge clk_i) begin
    if (do_access && !req_i.write) begin
      rdata_q <= mem[line_sel];
    end
  end

  assign rsp_o.ack  = ack_q;
  assign rsp_o.data = rdata_q;

endmodule

`default_nettype wire
